/* rtl/csr_macros.svh */
// CSR unit constants
// Data width, CSR map, instruction field positions and Zicsr encodings
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// --------------------
// Data width
// --------------------
`define XLEN 32

// --------------------
// Machine CSR map
// --------------------
`define CSR_MSTATUS  12'h300 // Machine status
`define CSR_MISA     12'h301 // ISA description, read-only here
`define CSR_MTVEC    12'h305 // Trap vector base
`define CSR_MSCRATCH 12'h340 // Scratch for trap handlers
`define CSR_MEPC     12'h341 // Exception PC
`define CSR_MCAUSE   12'h342 // Trap cause
`define CSR_MTVAL    12'h343 // Bad address or instruction
`define CSR_MHARTID  12'hF14 // Hart ID, MRO space

// --------------------
// Instruction fields
// --------------------
`define RD_POS     7  // rd, 5 bits
`define FUNCT3_POS 12 // funct3, 3 bits
`define RS1_POS    15 // rs1 or zimm, 5 bits
`define CSR_POS    20 // CSR address, 12 bits

// Zicsr funct3 codes
`define F3_CSRRW  3'b001
`define F3_CSRRS  3'b010
`define F3_CSRRC  3'b011
`define F3_CSRRWI 3'b101
`define F3_CSRRSI 3'b110
`define F3_CSRRCI 3'b111

// mstatus bits that hold state: 31, 22:11, 8:7, 5:3, 1:0
// WPRI fields stay zero
`define MSTATUS_WR_MASK 32'h807F_F9BB

// MXL = 1 (32 bit), I base only
`define MISA_VALUE 32'h4000_0100

`endif

/* rtl/riscv_isa_pkg.sv */
// RISC-V ISA vector types
// Words, register and CSR addresses, instruction subfields
`include "csr_macros.svh"

package riscv_isa_pkg;

    // --------------------
    // Data and instruction
    // --------------------
    typedef logic [`XLEN-1:0] xlen_t; // Register-width word
    typedef logic [31:0]      instr_t; // Fixed 32-bit encoding

    // --------------------
    // Addresses
    // --------------------
    typedef logic [4:0]  reg_addr_t; // x0..x31
    typedef logic [11:0] csr_addr_t; // 4096 CSR slots

    // Subfields
    typedef logic [2:0] funct3_t; // Selects the Zicsr operation
    typedef logic [4:0] zimm_t;   // Unsigned immediate in the rs1 slot

endpackage

/* rtl/csr_pipe_pkg.sv */
// CSR pipeline payloads
// Stage-to-stage operation, rd write-back and the CSR shared bus
package csr_pipe_pkg;

    import riscv_isa_pkg::*;

    // --------------------
    // Decode to execute
    // --------------------
    typedef struct packed {
        funct3_t   funct3;   // Operation code
        csr_addr_t csr_addr; // Target CSR
        reg_addr_t rd;       // Destination register
        logic      is_imm;   // Immediate form, operand is zimm
        logic      src_zero; // rs1 field is zero, set/clear only read
        xlen_t     operand;  // rs1 value or zero-extended zimm
    } csr_op_t;

    // Write-back to the integer register file
    typedef struct packed {
        reg_addr_t rd;
        xlen_t     data; // Old CSR value
    } csr_wb_t;

    // CSRs seen by the rest of the core
    typedef struct packed {
        xlen_t mtvec;
        xlen_t mepc;
        xlen_t mstatus;
    } csr_sb_t;

endpackage

/* rtl/csr_decode_stage.sv */
// CSR decode stage
// Splits the Zicsr instruction, fetches rs1 and screens read-only writes
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_decode_stage (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   instr_valid,
    output logic                   instr_ready,
    input  riscv_isa_pkg::instr_t  instr,
    output riscv_isa_pkg::reg_addr_t rs1_addr,
    input  riscv_isa_pkg::xlen_t   rs1_val,
    output logic                   op_valid,
    input  logic                   op_ready,
    output csr_pipe_pkg::csr_op_t  op,
    output logic                   ro_trap
);

    import riscv_isa_pkg::*;
    import csr_pipe_pkg::*;

    reg_addr_t rd;
    funct3_t   funct3;
    reg_addr_t rs1;
    zimm_t     zimm;
    csr_addr_t csr;
    logic      is_imm;
    logic      src_zero;
    logic      ro_violation;
    logic      accept;
    csr_op_t   next_op;

    // --------------------
    // Field split
    // --------------------
    assign rd     = instr[`RD_POS +: $bits(reg_addr_t)];
    assign funct3 = instr[`FUNCT3_POS +: $bits(funct3_t)];
    assign rs1    = instr[`RS1_POS +: $bits(reg_addr_t)];
    assign zimm   = instr[`RS1_POS +: $bits(zimm_t)]; // Same slot as rs1
    assign csr    = instr[`CSR_POS +: $bits(csr_addr_t)];

    assign rs1_addr = rs1; // Register file answers this cycle
    assign is_imm   = funct3[2];
    assign src_zero = (rs1 == '0); // x0 or zimm of zero

    // Top two address bits 11 mark read-only space
    // RW forms always write, set/clear only with a nonzero source
    assign ro_violation = (csr[11:10] == 2'b11) &&
                          ((funct3 == `F3_CSRRW) || (funct3 == `F3_CSRRWI) ||
                           (!src_zero && ((funct3 == `F3_CSRRS)  || (funct3 == `F3_CSRRC) ||
                                          (funct3 == `F3_CSRRSI) || (funct3 == `F3_CSRRCI))));

    always_comb begin
        next_op.funct3   = funct3;
        next_op.csr_addr = csr;
        next_op.rd       = rd;
        next_op.is_imm   = is_imm;
        next_op.src_zero = src_zero;
        next_op.operand  = is_imm ? xlen_t'(zimm) : rs1_val; // Zero-extend zimm
    end

    // --------------------
    // Stage register
    // --------------------
    assign instr_ready = !op_valid || op_ready; // Empty or draining
    assign accept      = instr_valid && instr_ready;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            op_valid <= 1'b0;
            ro_trap  <= 1'b0;
        end else begin
            ro_trap <= accept && ro_violation; // One-cycle pulse
            if (instr_ready) begin
                op_valid <= accept && !ro_violation; // Illegal ones die here
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (accept && !ro_violation) begin
            op <= next_op;
        end
    end

endmodule

/* rtl/csr_execute_stage.sv */
// CSR execute stage
// Read-modify-write of the addressed CSR and registered rd write-back
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_execute_stage (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      op_valid,
    output logic                      op_ready,
    input  csr_pipe_pkg::csr_op_t     op,
    output riscv_isa_pkg::csr_addr_t  rd_addr,
    input  riscv_isa_pkg::xlen_t      rd_data,
    output logic                      wr_en,
    output riscv_isa_pkg::csr_addr_t  wr_addr,
    output riscv_isa_pkg::xlen_t      wr_data,
    output logic                      wb_valid,
    input  logic                      wb_ready,
    output csr_pipe_pkg::csr_wb_t     wb
);

    import riscv_isa_pkg::*;
    import csr_pipe_pkg::*;

    xlen_t old_val;
    xlen_t new_val;
    logic  write_req;
    logic  commit;

    // --------------------
    // CSR read
    // --------------------
    assign rd_addr = op.csr_addr; // Combinational read port
    assign old_val = rd_data;

    // New value and write request per funct3
    always_comb begin
        new_val   = old_val;
        write_req = 1'b0;
        case (op.funct3)
            `F3_CSRRW, `F3_CSRRWI: begin
                new_val   = op.operand; // Plain swap
                write_req = 1'b1;
            end
            `F3_CSRRS, `F3_CSRRSI: begin
                new_val   = old_val | op.operand; // Set masked bits
                write_req = !op.src_zero;
            end
            `F3_CSRRC, `F3_CSRRCI: begin
                new_val   = old_val & ~op.operand; // Clear masked bits
                write_req = !op.src_zero;
            end
            default: begin
                write_req = 1'b0; // Not a Zicsr code, read only
            end
        endcase
    end

    // --------------------
    // Commit
    // --------------------
    assign op_ready = !wb_valid || wb_ready; // Stall holds everything
    assign commit   = op_valid && op_ready;

    assign wr_en   = commit && write_req; // Same edge as op handshake
    assign wr_addr = op.csr_addr;
    assign wr_data = new_val;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wb_valid <= 1'b0;
        end else if (op_ready) begin
            wb_valid <= op_valid;
        end
    end

    // rd gets the value from before the update
    always_ff @(posedge aclk) begin
        if (commit) begin
            wb.rd   <= op.rd;
            wb.data <= old_val;
        end
    end

endmodule

/* rtl/csr_regfile.sv */
// Machine CSR storage
// Per-register write rules, combinational read and the shared CSR bus
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_regfile #(
    parameter int unsigned mhart_id = 0
) (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  riscv_isa_pkg::csr_addr_t rd_addr,
    output riscv_isa_pkg::xlen_t     rd_data,
    input  logic                     wr_en,
    input  riscv_isa_pkg::csr_addr_t wr_addr,
    input  riscv_isa_pkg::xlen_t     wr_data,
    output csr_pipe_pkg::csr_sb_t    csr_sb
);

    import riscv_isa_pkg::*;
    import csr_pipe_pkg::*;

    // --------------------
    // Storage
    // --------------------
    xlen_t mstatus;  // WPRI bits held at zero
    xlen_t mtvec;
    xlen_t mscratch;
    xlen_t mepc;     // IALIGN 32, low bits zero
    xlen_t mcause;
    xlen_t mtval;
    xlen_t misa;
    xlen_t mhartid;

    assign misa    = `MISA_VALUE;     // Fixed RV32I
    assign mhartid = xlen_t'(mhart_id);

    // Writes land on the next edge
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mstatus  <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (wr_en) begin
            case (wr_addr)
                `CSR_MSTATUS:  mstatus  <= wr_data & `MSTATUS_WR_MASK;
                `CSR_MTVEC:    mtvec    <= wr_data;
                `CSR_MSCRATCH: mscratch <= wr_data;
                `CSR_MEPC:     mepc     <= {wr_data[`XLEN-1:2], 2'b00};
                `CSR_MCAUSE:   mcause   <= wr_data;
                `CSR_MTVAL:    mtval    <= wr_data;
                default: begin
                    // misa, mhartid and unmapped slots drop the write
                end
            endcase
        end
    end

    // --------------------
    // Read port
    // --------------------
    always_comb begin
        case (rd_addr)
            `CSR_MSTATUS:  rd_data = mstatus;
            `CSR_MISA:     rd_data = misa;
            `CSR_MTVEC:    rd_data = mtvec;
            `CSR_MSCRATCH: rd_data = mscratch;
            `CSR_MEPC:     rd_data = mepc;
            `CSR_MCAUSE:   rd_data = mcause;
            `CSR_MTVAL:    rd_data = mtval;
            `CSR_MHARTID:  rd_data = mhartid;
            default:       rd_data = '0; // Unmapped reads zero
        endcase
    end

    // Shared bus follows the registers directly
    always_comb begin
        csr_sb.mtvec   = mtvec;
        csr_sb.mepc    = mepc;
        csr_sb.mstatus = mstatus;
    end

endmodule

/* rtl/csr_unit_top.sv */
// CSR unit top level
// Decode and execute stages around the machine CSR file
`timescale 1ns/1ps

module csr_unit_top #(
    parameter int unsigned mhart_id = 0
) (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  logic                     instr_valid,
    output logic                     instr_ready,
    input  riscv_isa_pkg::instr_t    instr,
    output riscv_isa_pkg::reg_addr_t rs1_addr,
    input  riscv_isa_pkg::xlen_t     rs1_val,
    output logic                     wb_valid,
    input  logic                     wb_ready,
    output csr_pipe_pkg::csr_wb_t    wb,
    output logic                     ro_trap,
    output csr_pipe_pkg::csr_sb_t    csr_sb
);

    import riscv_isa_pkg::*;
    import csr_pipe_pkg::*;

    // --------------------
    // Stage links
    // --------------------
    logic      op_valid;
    logic      op_ready;
    csr_op_t   op;
    csr_addr_t rd_addr;  // Execute reads CSR
    xlen_t     rd_data;
    logic      wr_en;    // Execute commits CSR
    csr_addr_t wr_addr;
    xlen_t     wr_data;

    csr_decode_stage u_decode (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .rs1_addr    (rs1_addr),
        .rs1_val     (rs1_val),
        .op_valid    (op_valid),
        .op_ready    (op_ready),
        .op          (op),
        .ro_trap     (ro_trap)
    );

    csr_execute_stage u_execute (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .op_valid (op_valid),
        .op_ready (op_ready),
        .op       (op),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wb_valid (wb_valid),
        .wb_ready (wb_ready),
        .wb       (wb)
    );

    csr_regfile #(
        .mhart_id (mhart_id)
    ) u_regfile (
        .aclk    (aclk),
        .aresetn (aresetn),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .csr_sb  (csr_sb)
    );

endmodule

/* dv/tb_clock_gen.sv */
// Testbench clock and reset
// 100 ns clock, active-low reset held for 8 cycles
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period       = 100,
    parameter int reset_cycles = 8
) (
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk = 1'b0;
        forever #(period / 2) aclk = ~aclk;
    end

    initial begin
        aresetn = 1'b0; // Held from time zero
        repeat (reset_cycles) @(posedge aclk);
        #10 aresetn = 1'b1; // Release clear of the edge
    end

endmodule

/* dv/csr_unit_tb.sv */
// CSR unit testbench
// Directed and random Zicsr traffic checked against a reference CSR model
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_unit_tb;

    import riscv_isa_pkg::*;
    import csr_pipe_pkg::*;

    localparam int unsigned hart_id   = 5;
    localparam int          max_wait  = 200;       // Cycles per wait loop
    localparam logic [6:0]  op_system = 7'b1110011; // SYSTEM major opcode

    // Writable mstatus bits 31, 22:11, 8:7, 5:3 and 1:0
    localparam xlen_t mstatus_wr_bits = (xlen_t'(1) << 31) | (xlen_t'(12'hFFF) << 11) |
                                        (xlen_t'(2'b11) << 7) | (xlen_t'(3'b111) << 3) |
                                        xlen_t'(2'b11);

    logic      aclk;
    logic      aresetn;
    logic      instr_valid;
    logic      instr_ready;
    instr_t    instr;
    reg_addr_t rs1_addr;
    xlen_t     rs1_val;
    logic      wb_valid;
    logic      wb_ready;
    csr_wb_t   wb;
    logic      ro_trap;
    csr_sb_t   csr_sb;

    logic      force_ones;   // All-ones rs1 for the mask checks
    logic      random_stall; // Random wb_ready back-pressure
    int        err_count;
    xlen_t     model_csr [4096]; // Reference CSR space
    csr_wb_t   exp_q [$];        // Expected write-backs in arrival order

    tb_clock_gen u_clk (
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    csr_unit_top #(
        .mhart_id (hart_id)
    ) uut (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .rs1_addr    (rs1_addr),
        .rs1_val     (rs1_val),
        .wb_valid    (wb_valid),
        .wb_ready    (wb_ready),
        .wb          (wb),
        .ro_trap     (ro_trap),
        .csr_sb      (csr_sb)
    );

    // --------------------
    // Register file stub
    // --------------------
    function automatic xlen_t rs1_value(reg_addr_t r, logic ones);
        if (ones) begin
            return '1;
        end
        return (xlen_t'(r) * 32'h0101_0101) ^ 32'h5A5A_0000;
    endfunction

    assign rs1_val = rs1_value(rs1_addr, force_ones); // Same-cycle answer

    task automatic fail_stop(input string msg);
        err_count++;
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input string what, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("error at time %0t: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    // --------------------
    // Reference model
    // --------------------
    function automatic void model_reset();
        foreach (model_csr[i]) begin
            model_csr[i] = '0;
        end
        model_csr[`CSR_MISA]    = `MISA_VALUE;
        model_csr[`CSR_MHARTID] = xlen_t'(hart_id);
    endfunction

    function automatic void model_write(csr_addr_t csr, xlen_t val);
        case (csr)
            `CSR_MSTATUS: model_csr[csr] = val & mstatus_wr_bits; // WPRI reads zero
            `CSR_MEPC:    model_csr[csr] = {val[31:2], 2'b00};     // Word aligned
            `CSR_MTVEC, `CSR_MSCRATCH, `CSR_MCAUSE, `CSR_MTVAL: begin
                model_csr[csr] = val;
            end
            default: begin
                // misa, mhartid and unmapped slots keep their value
            end
        endcase
    endfunction

    // Write to read-only space by an RW form or a nonzero set/clear
    function automatic bit is_illegal(instr_t ins);
        csr_addr_t csr;
        funct3_t   f3;
        reg_addr_t src;
        csr = ins[31:20];
        f3  = ins[14:12];
        src = ins[19:15];
        return (csr[11:10] == 2'b11) && ((f3[1:0] == 2'b01) || (src != 0));
    endfunction

    // Returns the old value and updates the model
    function automatic xlen_t model_apply(instr_t ins, logic ones);
        csr_addr_t csr;
        funct3_t   f3;
        reg_addr_t src;
        xlen_t     operand;
        xlen_t     old_val;
        csr     = ins[31:20];
        f3      = ins[14:12];
        src     = ins[19:15];
        operand = f3[2] ? xlen_t'(src) : rs1_value(src, ones); // zimm is unsigned
        old_val = model_csr[csr];
        case (f3[1:0])
            2'b01: model_write(csr, operand);
            2'b10: if (src != 0) model_write(csr, old_val | operand);
            2'b11: if (src != 0) model_write(csr, old_val & ~operand);
            default: begin
                // Not generated
            end
        endcase
        return old_val;
    endfunction

    function automatic instr_t csr_instr(funct3_t f3, csr_addr_t csr, reg_addr_t src,
                                         reg_addr_t rd);
        return {csr, src, f3, rd, op_system};
    endfunction

    // --------------------
    // Driver
    // --------------------
    task automatic send_instr(input instr_t ins);
        int      waited;
        bit      illegal;
        csr_wb_t exp_wb;
        waited      = 0;
        instr_valid = 1'b1;
        instr       = ins;
        @(negedge aclk);
        while (!instr_ready) begin // Stable at mid-cycle
            waited++;
            if (waited > max_wait) fail_stop("timeout: instr_ready stayed low");
            @(negedge aclk);
        end
        check_value("rs1_addr", xlen_t'(rs1_addr), xlen_t'(ins[19:15])); // rs1 field
        @(posedge aclk); // Handshake edge
        #10;
        instr_valid = 1'b0;
        illegal     = is_illegal(ins);
        check_value("ro_trap", xlen_t'(ro_trap), xlen_t'(illegal)); // Pulse right after accept
        if (!illegal) begin
            exp_wb.rd   = ins[11:7];
            exp_wb.data = model_apply(ins, force_ones);
            exp_q.push_back(exp_wb);
        end
    endtask

    // Lets the pipe empty and then compares the shared bus
    task automatic drain_and_check_bus();
        int waited;
        waited       = 0;
        random_stall = 1'b0;
        while (exp_q.size() != 0 || wb_valid) begin
            @(posedge aclk);
            #10;
            waited++;
            if (waited > max_wait) fail_stop("timeout: write-backs did not drain");
        end
        check_value("csr_sb.mtvec", csr_sb.mtvec, model_csr[`CSR_MTVEC]);
        check_value("csr_sb.mepc", csr_sb.mepc, model_csr[`CSR_MEPC]);
        check_value("csr_sb.mstatus", csr_sb.mstatus, model_csr[`CSR_MSTATUS]);
    endtask

    // --------------------
    // Write-back checker
    // --------------------
    always @(negedge aclk) begin : wb_checker
        csr_wb_t exp_wb;
        if (aresetn && wb_valid && wb_ready) begin // Handshake at next edge
            if (exp_q.size() == 0) begin
                fail_stop("write-back seen with no instruction outstanding");
            end else begin
                exp_wb = exp_q.pop_front();
                check_value("wb.rd", xlen_t'(wb.rd), xlen_t'(exp_wb.rd));
                check_value("wb.data", wb.data, exp_wb.data);
            end
        end
    end

    // Mode sampled at the edge and driven 10 ns later
    always @(posedge aclk) begin : backpressure
        logic stall_now;
        stall_now = random_stall;
        #10;
        wb_ready = stall_now ? ($urandom_range(0, 1) == 1) : 1'b1;
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin : stimulus
        funct3_t   f3_list [6];
        csr_addr_t addr_list [11];
        csr_addr_t rw_list [4];
        int        waited;
        funct3_t   f3;
        csr_addr_t csr;
        reg_addr_t src;
        reg_addr_t rd;
        void'($urandom(73754));
        f3_list   = '{`F3_CSRRW, `F3_CSRRS, `F3_CSRRC, `F3_CSRRWI, `F3_CSRRSI, `F3_CSRRCI};
        addr_list = '{`CSR_MSTATUS, `CSR_MISA, `CSR_MTVEC, `CSR_MSCRATCH, `CSR_MEPC,
                      `CSR_MCAUSE, `CSR_MTVAL, `CSR_MHARTID, 12'h7C0, 12'hC00, 12'h3A0};
        rw_list   = '{`CSR_MSCRATCH, `CSR_MTVEC, `CSR_MCAUSE, `CSR_MTVAL};
        instr_valid  = 1'b0;
        instr        = '0;
        wb_ready     = 1'b1;
        force_ones   = 1'b0;
        random_stall = 1'b0;
        err_count    = 0;
        model_reset();

        waited = 0;
        while (aresetn !== 1'b1) begin
            @(posedge aclk);
            waited++;
            if (waited > max_wait) fail_stop("timeout: reset was never released");
        end
        @(posedge aclk);
        #10;
        check_value("wb_valid after reset", xlen_t'(wb_valid), '0);
        check_value("ro_trap after reset", xlen_t'(ro_trap), '0);
        drain_and_check_bus(); // All zero out of reset

        // Swaps return the old value and the read after returns the new one
        foreach (rw_list[i]) begin
            send_instr(csr_instr(`F3_CSRRW, rw_list[i], reg_addr_t'(i + 4), 5'd1));
            send_instr(csr_instr(`F3_CSRRS, rw_list[i], 5'd0, 5'd2));
            send_instr(csr_instr(`F3_CSRRWI, rw_list[i], 5'd21, 5'd3));
            send_instr(csr_instr(`F3_CSRRS, rw_list[i], 5'd0, 5'd4));
        end
        drain_and_check_bus();

        // Set and clear and then zero sources that only read
        send_instr(csr_instr(`F3_CSRRS, `CSR_MSCRATCH, 5'd7, 5'd5));
        send_instr(csr_instr(`F3_CSRRC, `CSR_MSCRATCH, 5'd12, 5'd6));
        send_instr(csr_instr(`F3_CSRRSI, `CSR_MTVEC, 5'h1F, 5'd7));
        send_instr(csr_instr(`F3_CSRRCI, `CSR_MTVEC, 5'h0A, 5'd8));
        send_instr(csr_instr(`F3_CSRRC, `CSR_MSCRATCH, 5'd0, 5'd9));
        send_instr(csr_instr(`F3_CSRRSI, `CSR_MTVEC, 5'd0, 5'd10));
        send_instr(csr_instr(`F3_CSRRCI, `CSR_MSCRATCH, 5'd0, 5'd11));
        send_instr(csr_instr(`F3_CSRRS, `CSR_MTVEC, 5'd0, 5'd12));
        drain_and_check_bus();

        // All ones into mstatus and mepc
        force_ones = 1'b1;
        send_instr(csr_instr(`F3_CSRRW, `CSR_MSTATUS, 5'd9, 5'd13));
        send_instr(csr_instr(`F3_CSRRW, `CSR_MEPC, 5'd9, 5'd14));
        force_ones = 1'b0;
        send_instr(csr_instr(`F3_CSRRS, `CSR_MSTATUS, 5'd0, 5'd15));
        send_instr(csr_instr(`F3_CSRRS, `CSR_MEPC, 5'd0, 5'd16));
        drain_and_check_bus();
        check_value("mstatus writable bits", csr_sb.mstatus, mstatus_wr_bits);
        check_value("mepc alignment", csr_sb.mepc, 32'hFFFF_FFFC);

        // Constants, unmapped slots and the read-only trap
        send_instr(csr_instr(`F3_CSRRS, `CSR_MISA, 5'd0, 5'd17));
        send_instr(csr_instr(`F3_CSRRS, `CSR_MHARTID, 5'd0, 5'd18));
        send_instr(csr_instr(`F3_CSRRS, 12'h7C0, 5'd0, 5'd19));
        send_instr(csr_instr(`F3_CSRRW, `CSR_MHARTID, 5'd3, 5'd20)); // Traps
        send_instr(csr_instr(`F3_CSRRW, `CSR_MISA, 5'd3, 5'd21));    // Dropped write
        send_instr(csr_instr(`F3_CSRRS, `CSR_MISA, 5'd0, 5'd22));
        send_instr(csr_instr(`F3_CSRRSI, `CSR_MHARTID, 5'd0, 5'd23));
        drain_and_check_bus();

        // Random traffic under back-pressure
        random_stall = 1'b1;
        repeat (300) begin
            f3  = f3_list[$urandom_range(0, 5)];
            csr = addr_list[$urandom_range(0, 10)];
            src = ($urandom_range(0, 3) == 0) ? 5'd0 : reg_addr_t'($urandom_range(1, 31));
            rd  = reg_addr_t'($urandom_range(0, 31));
            send_instr(csr_instr(f3, csr, src, rd));
        end
        drain_and_check_bus(); // Nothing lost or left over

        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+rtl
rtl/riscv_isa_pkg.sv
rtl/csr_pipe_pkg.sv
rtl/csr_decode_stage.sv
rtl/csr_execute_stage.sv
rtl/csr_regfile.sv
rtl/csr_unit_top.sv
dv/tb_clock_gen.sv
dv/csr_unit_tb.sv
